/* Makefile */
# Verilator build and run for the AHB-Lite USB endpoint
VERILATOR ?= verilator
TOP       ?= tb_ahb_usb_endpoint
RTL_TOP   ?= ahb_usb_endpoint
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -F -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* ahb_pkg.sv */
// AHB-Lite bus definitions for the endpoint slave
// Bus widths, HTRANS and HSIZE codes, the address-phase request
// and the accepted transfer carried through its data phase
package ahb_pkg;

	// Bus and field widths
	localparam int HADDR_W  = 4;
	localparam int HDATA_W  = 32;
	localparam int NBYTES_W = 3;

	typedef logic [HADDR_W-1:0]  haddr_t;
	typedef logic [HDATA_W-1:0]  hdata_t;
	typedef logic [2:0]          hsize_t;
	typedef logic [1:0]          htrans_t;
	typedef logic [NBYTES_W-1:0] nbytes_t;

	// HTRANS codes
	localparam htrans_t TRANS_IDLE = 2'd0;
	localparam htrans_t TRANS_BUSY = 2'd1;
	localparam htrans_t TRANS_NSEQ = 2'd2;
	localparam htrans_t TRANS_SEQ  = 2'd3;

	// HSIZE codes, only up to one word
	localparam hsize_t SIZE_BYTE = 3'd0;
	localparam hsize_t SIZE_HALF = 3'd1;
	localparam hsize_t SIZE_WORD = 3'd2;

	// Address phase from the master
	typedef struct packed {
		logic    hsel;
		htrans_t htrans;
		haddr_t  haddr;
		hsize_t  hsize;
		logic    hwrite;
	} ahb_req_t;

	// Accepted transfer, held for its data phase
	typedef struct packed {
		logic    valid;
		haddr_t  addr;
		hsize_t  size;
		logic    write;
		logic    is_buffer;
		nbytes_t nbytes;
	} access_t;

endpackage

/* ahb_slave_frontend.sv */
// AHB-Lite slave front end
// Captures the address phase, decodes the register map and size,
// runs the two-cycle error response and stretches hready while
// the buffer sequencer is busy
`timescale 1ns/1ns

module ahb_slave_frontend (
	input  logic              tb_clk,
	input  logic              reset,
	input  ahb_pkg::ahb_req_t req,
	input  logic              buffer_busy,
	output ahb_pkg::access_t  access,
	output logic              hready,
	output logic              hresp
);
	import ahb_pkg::*;
	import usb_ep_pkg::*;

	typedef enum logic [1:0] {IDLE, DATA, ERR1, ERR2} fe_state_t;

	fe_state_t state;
	logic      active;
	logic      accept;
	logic      hit_buffer;
	logic      hit_ro;
	logic      hit_ctrl;
	logic      addr_ok;
	logic      align_ok;
	logic      legal;
	nbytes_t   nbytes;

	// BUSY counts as IDLE, no bursts here
	always_comb
	begin
		case (req.htrans)
			TRANS_NSEQ, TRANS_SEQ: active = 1'b1;
			TRANS_IDLE, TRANS_BUSY: active = 1'b0;
		endcase
	end

	assign accept = hready && req.hsel && active;

	// ************************************************************
	// Register map decode
	// ************************************************************
	assign hit_buffer = (req.haddr[3:2] == ADDR_BUFFER[3:2]);
	// Status, error and occupancy are read-only
	assign hit_ro   = (req.haddr >= ADDR_STATUS) && (req.haddr <= ADDR_OCCUPANCY);
	assign hit_ctrl = (req.haddr == ADDR_TX_CTRL) || (req.haddr == ADDR_FLUSH);
	assign addr_ok  = hit_buffer || hit_ctrl || (hit_ro && !req.hwrite);

	// Byte count and alignment per size
	always_comb
	begin
		nbytes   = '0;
		align_ok = 1'b0;
		case (req.hsize)
			SIZE_BYTE:
			begin
				nbytes   = 3'd1;
				align_ok = 1'b1;
			end
			SIZE_HALF:
			begin
				nbytes   = 3'd2;
				align_ok = !req.haddr[0];
			end
			// Word only at the buffer base
			SIZE_WORD:
			begin
				nbytes   = 3'd4;
				align_ok = (req.haddr == ADDR_BUFFER);
			end
			default:
			begin
				nbytes   = '0;
				align_ok = 1'b0;
			end
		endcase
	end

	assign legal = addr_ok && align_ok;

	// ************************************************************
	// Data phase control
	// ************************************************************
	always_ff @(posedge tb_clk)
	begin
		if (reset)
			state <= IDLE;
		else if (hready)
			state <= !accept ? IDLE : (legal ? DATA : ERR1);
		else if (state == ERR1)
			state <= ERR2;
	end

	// Only legal transfers reach the register and buffer blocks
	always_ff @(posedge tb_clk)
	begin
		if (reset)
			access <= '0;
		else if (hready)
		begin
			access.valid     <= accept && legal;
			access.addr      <= req.haddr;
			access.size      <= req.hsize;
			access.write     <= req.hwrite;
			access.is_buffer <= hit_buffer;
			access.nbytes    <= nbytes;
		end
	end

	always_comb
	begin
		hready = 1'b1;
		hresp  = 1'b0;
		case (state)
			IDLE: hready = 1'b1;
			// Stretched while bytes move
			DATA: hready = !buffer_busy;
			ERR1:
			begin
				hready = 1'b0;
				hresp  = 1'b1;
			end
			ERR2: hresp = 1'b1;
		endcase
	end

endmodule

/* ahb_usb_endpoint.sv */
// AHB-Lite USB endpoint slave, top level
// Joins the bus front end, the status registers and the data
// buffer sequencer, and muxes the read data
`timescale 1ns/1ns

module ahb_usb_endpoint (
	input  logic                   tb_clk,
	input  logic                   reset,
	input  ahb_pkg::ahb_req_t      req,
	input  ahb_pkg::hdata_t        hwdata,
	output ahb_pkg::hdata_t        hrdata,
	output logic                   hresp,
	output logic                   hready,
	input  usb_ep_pkg::rx_status_t rx_status,
	input  usb_ep_pkg::tx_status_t tx_status,
	input  usb_ep_pkg::occupancy_t buffer_occupancy,
	input  usb_ep_pkg::byte_t      rx_data,
	output logic                   get_rx_data,
	output logic                   store_tx_data,
	output usb_ep_pkg::byte_t      tx_data,
	output usb_ep_pkg::packet_t    tx_packet,
	output logic                   clear
);
	import ahb_pkg::*;

	access_t access;
	logic    buffer_busy;
	hdata_t  buffer_rdata;
	hdata_t  reg_rdata;

	// ************************************************************
	// Bus side
	// ************************************************************
	ahb_slave_frontend u_frontend (
		.tb_clk      (tb_clk),
		.reset       (reset),
		.req         (req),
		.buffer_busy (buffer_busy),
		.access      (access),
		.hready      (hready),
		.hresp       (hresp)
	);

	// Receiver and transmitter status, control
	usb_status_regs u_status_regs (
		.tb_clk           (tb_clk),
		.reset            (reset),
		.access           (access),
		.hwdata           (hwdata),
		.rx_status        (rx_status),
		.tx_status        (tx_status),
		.buffer_occupancy (buffer_occupancy),
		.reg_rdata        (reg_rdata),
		.tx_packet        (tx_packet),
		.clear            (clear)
	);

	// Data buffer
	buffer_sequencer u_buffer_sequencer (
		.tb_clk        (tb_clk),
		.reset         (reset),
		.access        (access),
		.hwdata        (hwdata),
		.rx_data       (rx_data),
		.buffer_busy   (buffer_busy),
		.buffer_rdata  (buffer_rdata),
		.get_rx_data   (get_rx_data),
		.store_tx_data (store_tx_data),
		.tx_data       (tx_data)
	);

	// Read data by target
	assign hrdata = access.is_buffer ? buffer_rdata : reg_rdata;

endmodule

/* buffer_sequencer.sv */
// Data buffer sequencer
// Moves a buffer access one byte per cycle, least significant first,
// pulsing store_tx_data or get_rx_data once per byte and keeping the
// bus stalled until the last byte has gone
`timescale 1ns/1ns

module buffer_sequencer (
	input  logic              tb_clk,
	input  logic              reset,
	input  ahb_pkg::access_t  access,
	input  ahb_pkg::hdata_t   hwdata,
	input  usb_ep_pkg::byte_t rx_data,
	output logic              buffer_busy,
	output ahb_pkg::hdata_t   buffer_rdata,
	output logic              get_rx_data,
	output logic              store_tx_data,
	output usb_ep_pkg::byte_t tx_data
);
	import ahb_pkg::*;

	typedef enum logic [1:0] {IDLE, READ, WRITE} seq_state_t;

	seq_state_t state;
	nbytes_t    count;
	logic       in_phase;
	logic       xfer;
	logic [1:0] lane;

	assign in_phase = access.valid && access.is_buffer;
	// Current byte lane, offset by the start address
	assign lane = access.addr[1:0] + count[1:0];

	// First byte moves in the first data phase cycle
	always_comb
	begin
		case (state)
			IDLE: xfer = in_phase;
			default: xfer = (count != access.nbytes);
		endcase
	end

	assign buffer_busy   = xfer;
	assign get_rx_data   = xfer && !access.write;
	assign store_tx_data = xfer && access.write;
	// hwdata stays put while hready is low
	assign tx_data = hwdata[{lane, 3'b000} +: 8];

	// ************************************************************
	// Byte counter
	// ************************************************************
	always_ff @(posedge tb_clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			count <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				if (in_phase)
				begin
					state <= access.write ? WRITE : READ;
					count <= 3'd1;
				end
				// Done cycle returns to idle with hready high
				READ, WRITE:
				if (xfer)
					count <= count + 3'd1;
				else
				begin
					state <= IDLE;
					count <= '0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Read assembly, rx_data is fall-through
	always_ff @(posedge tb_clk)
	begin
		if (state == IDLE && get_rx_data)
			buffer_rdata <= hdata_t'(rx_data) << {lane, 3'b000};
		else if (state == READ && get_rx_data)
			buffer_rdata[{lane, 3'b000} +: 8] <= rx_data;
	end

endmodule

/* sources.f */
ahb_pkg.sv
usb_ep_pkg.sv
ahb_slave_frontend.sv
usb_status_regs.sv
buffer_sequencer.sv
ahb_usb_endpoint.sv
tb_clock_gen.sv
tb_ahb_usb_endpoint.sv

/* tb_ahb_usb_endpoint.sv */
// Testbench for the AHB-Lite USB endpoint slave
// Acts as the bus master, models the receiver and transmitter side,
// checks the register map, buffer sequencing and error responses
`timescale 1ns/1ns

module tb_ahb_usb_endpoint;
	import ahb_pkg::*;
	import usb_ep_pkg::*;

	logic       tb_clk;
	logic       reset;
	ahb_req_t   req;
	hdata_t     hwdata;
	hdata_t     hrdata;
	logic       hresp;
	logic       hready;
	rx_status_t rx_status;
	tx_status_t tx_status;
	occupancy_t buffer_occupancy;
	byte_t      rx_data;
	logic       get_rx_data;
	logic       store_tx_data;
	byte_t      tx_data;
	packet_t    tx_packet;
	logic       clear;

	// Transfer list for the master
	haddr_t      q_addr [16];
	hsize_t      q_size [16];
	logic        q_write [16];
	hdata_t      q_wdata [16];
	hdata_t      q_rdata [16];
	logic        q_resp [16];
	int          q_stall [16];
	int          q_n = 0;
	int          issued = 0;
	logic [31:0] rng_state;
	byte_t       rx_seen [$];
	byte_t       tx_seen [$];

	tb_clock_gen u_clock_gen (
		.tb_clk (tb_clk),
		.reset  (reset)
	);

	ahb_usb_endpoint u_ahb_usb_endpoint (
		.tb_clk           (tb_clk),
		.reset            (reset),
		.req              (req),
		.hwdata           (hwdata),
		.hrdata           (hrdata),
		.hresp            (hresp),
		.hready           (hready),
		.rx_status        (rx_status),
		.tx_status        (tx_status),
		.buffer_occupancy (buffer_occupancy),
		.rx_data          (rx_data),
		.get_rx_data      (get_rx_data),
		.store_tx_data    (store_tx_data),
		.tx_data          (tx_data),
		.tx_packet        (tx_packet),
		.clear            (clear)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else report_failure($sformatf("mismatch %s expected %h got %h", name, exp, got));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int size_bytes(input hsize_t size);
		case (size)
			SIZE_HALF: return 2;
			SIZE_WORD: return 4;
			default: return 1;
		endcase
	endfunction

	// Active byte lanes of a transfer
	function automatic hdata_t lane_mask(input haddr_t addr, input hsize_t size);
		hdata_t mask;
		int     base;
		mask = '0;
		base = int'(addr[1:0]);
		for (int k = 0; k < size_bytes(size); k++)
			mask = mask | (32'h0000_00FF << (8 * (base + k)));
		return mask;
	endfunction

	// Register word from the endpoint inputs, status 0x4 error 0x6 occupancy 0x8
	function automatic hdata_t expected_reg_word(input haddr_t addr);
		logic [15:0] status;
		logic [15:0] error;
		status    = '0;
		status[0] = rx_status.rx_data_ready;
		status[1] = (rx_status.rx_packet == PKT_IN);
		status[2] = (rx_status.rx_packet == PKT_OUT);
		status[3] = (rx_status.rx_packet == PKT_ACK);
		status[8] = rx_status.rx_transfer_active;
		status[9] = tx_status.tx_transfer_active;
		error     = '0;
		error[0]  = rx_status.rx_error;
		error[8]  = tx_status.tx_error;
		case (addr[3:2])
			2'b01: return {error, status};
			2'b10: return {25'h0, buffer_occupancy};
			default: return '0;
		endcase
	endfunction

	// ************************************************************
	// Bus master
	// ************************************************************
	task automatic add_transfer(input haddr_t addr, input hsize_t size,
		input logic write, input hdata_t wdata);
		q_addr[q_n]  = addr;
		q_size[q_n]  = size;
		q_write[q_n] = write;
		q_wdata[q_n] = wdata;
		q_n++;
	endtask

	task automatic drive_request(input int idx);
		ahb_req_t r;
		r.hsel   = 1'b1;
		r.htrans = TRANS_NSEQ;
		r.haddr  = q_addr[idx];
		r.hsize  = q_size[idx];
		r.hwrite = q_write[idx];
		req <= r;
		issued++;
	endtask

	// Pipelined run, next address phase overlaps the current data phase
	task automatic run_transfers();
		int addr_idx;
		int data_idx;
		int next;
		int stall;
		addr_idx = 0;
		data_idx = -1;
		next     = 1;
		stall    = 0;
		@(posedge tb_clk);
		drive_request(0);
		while (addr_idx >= 0 || data_idx >= 0)
		begin
			@(posedge tb_clk);
			if (!hready)
			begin
				stall++;
				if (stall > 16)
					report_failure("hready stayed low for more than 16 cycles");
			end
			else
			begin
				if (data_idx >= 0)
				begin
					q_rdata[data_idx] = hrdata;
					q_resp[data_idx]  = hresp;
					q_stall[data_idx] = stall;
				end
				stall    = 0;
				data_idx = addr_idx;
				if (data_idx >= 0)
					hwdata <= q_wdata[data_idx];
				if (next < q_n)
				begin
					drive_request(next);
					addr_idx = next;
					next++;
				end
				else
				begin
					req      <= '0;
					addr_idx = -1;
				end
			end
		end
	endtask

	task automatic check_response(input int idx, input logic exp_resp, input int exp_stall);
		check_value("hresp", 32'(q_resp[idx]), 32'(exp_resp));
		check_value("hready low cycles", 32'(q_stall[idx]), 32'(exp_stall));
	endtask

	// ************************************************************
	// Endpoint model, rx_data is first-word fall-through
	// ************************************************************
	initial
	begin
		logic [31:0] rx_rng;
		rx_rng  = xorshift32(32'd3529);
		rx_data = rx_rng[7:0];
		forever
		begin
			@(posedge tb_clk);
			if (!reset && get_rx_data)
			begin
				rx_seen.push_back(rx_data);
				rx_rng = xorshift32(rx_rng);
				rx_data <= rx_rng[7:0];
			end
			if (!reset && store_tx_data)
				tx_seen.push_back(tx_data);
		end
	end

	// Protocol checks
	err_second: assert property (@(posedge tb_clk) disable iff (reset)
		(hresp && !hready) |=> (hresp && hready))
	else report_failure("error response did not finish with hready high");
	err_first: assert property (@(posedge tb_clk) disable iff (reset)
		(hresp && hready) |-> $past(hresp && !hready))
	else report_failure("error response skipped its first cycle");
	strobe_stall: assert property (@(posedge tb_clk) disable iff (reset)
		(store_tx_data || get_rx_data) |-> !hready)
	else report_failure("buffer strobe seen while hready was high");
	strobe_excl: assert property (@(posedge tb_clk) disable iff (reset)
		!(store_tx_data && get_rx_data))
	else report_failure("get_rx_data and store_tx_data high together");
	tx_release: assert property (@(posedge tb_clk) disable iff (reset)
		$fell(tx_status.tx_transfer_active) |=> (tx_packet == PKT_NONE))
	else report_failure("tx_packet held after the transmitter finished");
	flush_hold: assert property (@(posedge tb_clk) disable iff (reset)
		(clear && buffer_occupancy != '0) |=> clear)
	else report_failure("clear dropped while the buffer still held data");

	// Watchdog, 200 cycles per issued transfer
	initial
	begin
		int cycles;
		cycles = 0;
		forever
		begin
			@(posedge tb_clk);
			cycles++;
			if (cycles > 200 * (issued + 1))
				report_failure($sformatf("watchdog timeout after %0d cycles", cycles));
		end
	end

	// ************************************************************
	// Test sequence
	// ************************************************************
	initial
	begin
		hsize_t     sizes [3];
		hdata_t     wdata;
		hdata_t     expected;
		hdata_t     mask;
		logic [31:0] rnd;
		rx_status_t rx_next;
		tx_status_t tx_next;
		int         waited;
		sizes            = '{SIZE_BYTE, SIZE_HALF, SIZE_WORD};
		rng_state        = 32'd3529;
		req              = '0;
		hwdata           = '0;
		rx_status        = '0;
		tx_status        = '0;
		buffer_occupancy = '0;
		@(posedge tb_clk);
		while (reset)
			@(posedge tb_clk);

		// Reset state
		check_value("hready", 32'(hready), 32'd1);
		check_value("hresp", 32'(hresp), 32'd0);
		check_value("tx_packet", 32'(tx_packet), 32'(PKT_NONE));
		check_value("clear", 32'(clear), 32'd0);
		check_value("get_rx_data", 32'(get_rx_data), 32'd0);
		check_value("store_tx_data", 32'(store_tx_data), 32'd0);

		// Buffer writes then reads, each size
		for (int s = 0; s < 3; s++)
		begin
			q_n = 0;
			tx_seen.delete();
			rx_seen.delete();
			wdata = next_random();
			add_transfer(ADDR_BUFFER, sizes[s], 1'b1, wdata);
			run_transfers();
			check_response(0, 1'b0, size_bytes(sizes[s]));
			check_value("store_tx_data pulses", tx_seen.size(), size_bytes(sizes[s]));
			check_value("get_rx_data pulses", rx_seen.size(), 0);
			for (int k = 0; k < size_bytes(sizes[s]); k++)
				check_value("tx_data", 32'(tx_seen[k]), (wdata >> (8 * k)) & 32'h0000_00FF);
		end
		for (int s = 0; s < 3; s++)
		begin
			q_n = 0;
			tx_seen.delete();
			rx_seen.delete();
			add_transfer(ADDR_BUFFER, sizes[s], 1'b0, '0);
			run_transfers();
			check_response(0, 1'b0, size_bytes(sizes[s]));
			check_value("get_rx_data pulses", rx_seen.size(), size_bytes(sizes[s]));
			check_value("store_tx_data pulses", tx_seen.size(), 0);
			expected = '0;
			for (int k = 0; k < rx_seen.size(); k++)
				expected = expected | (hdata_t'(rx_seen[k]) << (8 * k));
			mask = lane_mask(ADDR_BUFFER, sizes[s]);
			check_value("hrdata", q_rdata[0] & mask, expected & mask);
		end

		// Status, error and occupancy reads, back to back
		for (int i = 0; i < 4; i++)
		begin
			rnd                        = next_random();
			rx_next.rx_packet          = packet_t'({1'b0, rnd[1:0]});
			rx_next.rx_data_ready      = rnd[2];
			rx_next.rx_transfer_active = rnd[3];
			rx_next.rx_error           = rnd[4];
			tx_next.tx_transfer_active = rnd[5];
			tx_next.tx_error           = rnd[6];
			rx_status        <= rx_next;
			tx_status        <= tx_next;
			buffer_occupancy <= rnd[22:16];
			q_n = 0;
			add_transfer(ADDR_STATUS, SIZE_HALF, 1'b0, '0);
			add_transfer(ADDR_ERROR, SIZE_HALF, 1'b0, '0);
			add_transfer(ADDR_OCCUPANCY, SIZE_BYTE, 1'b0, '0);
			add_transfer(4'h4, SIZE_BYTE, 1'b0, '0);
			add_transfer(4'h5, SIZE_BYTE, 1'b0, '0);
			run_transfers();
			for (int t = 0; t < q_n; t++)
			begin
				check_response(t, 1'b0, 0);
				mask = lane_mask(q_addr[t], q_size[t]);
				check_value("hrdata", q_rdata[t] & mask, expected_reg_word(q_addr[t]) & mask);
			end
		end

		// TX packet control held until the transmitter goes idle
		tx_next.tx_transfer_active = 1'b1;
		tx_next.tx_error           = 1'b0;
		tx_status <= tx_next;
		q_n = 0;
		add_transfer(ADDR_TX_CTRL, SIZE_BYTE, 1'b1, 32'(PKT_IN));
		add_transfer(ADDR_TX_CTRL, SIZE_BYTE, 1'b0, '0);
		run_transfers();
		check_response(0, 1'b0, 0);
		check_response(1, 1'b0, 0);
		check_value("hrdata", q_rdata[1] & 32'h0000_00FF, 32'(PKT_IN));
		check_value("tx_packet", 32'(tx_packet), 32'(PKT_IN));
		tx_status.tx_transfer_active <= 1'b0;
		waited = 0;
		while (tx_packet != PKT_NONE)
		begin
			@(posedge tb_clk);
			waited++;
			if (waited > 4)
				report_failure("tx_packet did not return to NONE after the transmitter finished");
		end

		// Flush held until the buffer is empty
		buffer_occupancy <= 7'd5;
		q_n = 0;
		add_transfer(ADDR_FLUSH, SIZE_BYTE, 1'b1, 32'h0000_0100);
		add_transfer(ADDR_FLUSH, SIZE_BYTE, 1'b0, '0);
		run_transfers();
		check_response(0, 1'b0, 0);
		check_response(1, 1'b0, 0);
		check_value("hrdata", q_rdata[1] & 32'h0000_FF00, 32'h0000_0100);
		repeat (5)
		begin
			@(posedge tb_clk);
			check_value("clear", 32'(clear), 32'd1);
		end
		buffer_occupancy <= '0;
		waited = 0;
		while (clear)
		begin
			@(posedge tb_clk);
			waited++;
			if (waited > 4)
				report_failure("clear stayed high after the buffer emptied");
		end

		// Illegal addresses, read-only writes, misaligned sizes
		q_n = 0;
		tx_seen.delete();
		rx_seen.delete();
		add_transfer(4'h9, SIZE_BYTE, 1'b0, '0);
		add_transfer(4'hA, SIZE_BYTE, 1'b0, '0);
		add_transfer(4'hB, SIZE_BYTE, 1'b0, '0);
		add_transfer(4'hE, SIZE_BYTE, 1'b0, '0);
		add_transfer(4'hF, SIZE_BYTE, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'h4, SIZE_BYTE, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'h5, SIZE_BYTE, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'h6, SIZE_HALF, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'h7, SIZE_BYTE, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'h8, SIZE_BYTE, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'hD, SIZE_HALF, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'h1, SIZE_HALF, 1'b1, 32'hFFFF_FFFF);
		add_transfer(4'h3, SIZE_HALF, 1'b0, '0);
		add_transfer(4'h4, SIZE_WORD, 1'b0, '0);
		add_transfer(4'hC, SIZE_WORD, 1'b1, 32'hFFFF_FFFF);
		run_transfers();
		for (int t = 0; t < q_n; t++)
			check_response(t, 1'b1, 1);
		check_value("store_tx_data pulses", tx_seen.size(), 0);
		check_value("get_rx_data pulses", rx_seen.size(), 0);
		check_value("tx_packet", 32'(tx_packet), 32'(PKT_NONE));
		check_value("clear", 32'(clear), 32'd0);

		$display("Verification passed");
		$finish;
	end

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset source
// 20 ns clock, synchronous reset held high for the first 3 cycles
`timescale 1ns/1ns

module tb_clock_gen (
	output logic tb_clk,
	output logic reset
);

	// Half period of 10 ns
	initial
	begin
		tb_clk = 1'b0;
		forever
			#10 tb_clk = ~tb_clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (3)
			@(posedge tb_clk);
		reset <= 1'b0;
	end

endmodule

/* usb_ep_pkg.sv */
// USB endpoint definitions
// Register map, packet codes, status inputs from the receiver
// and transmitter, and the status and error register layouts
package usb_ep_pkg;

	// Register map, byte addresses
	localparam logic [3:0] ADDR_BUFFER    = 4'h0;
	localparam logic [3:0] ADDR_STATUS    = 4'h4;
	localparam logic [3:0] ADDR_ERROR     = 4'h6;
	localparam logic [3:0] ADDR_OCCUPANCY = 4'h8;
	localparam logic [3:0] ADDR_TX_CTRL   = 4'hC;
	localparam logic [3:0] ADDR_FLUSH     = 4'hD;

	typedef logic [7:0] byte_t;
	typedef logic [6:0] occupancy_t;

	// Packet codes shared by receiver and transmitter
	typedef enum logic [2:0] {
		PKT_NONE = 3'd0,
		PKT_OUT  = 3'd1,
		PKT_IN   = 3'd2,
		PKT_ACK  = 3'd3
	} packet_t;

	// Receiver side status
	typedef struct packed {
		packet_t rx_packet;
		logic    rx_data_ready;
		logic    rx_transfer_active;
		logic    rx_error;
	} rx_status_t;

	// Transmitter side status
	typedef struct packed {
		logic tx_transfer_active;
		logic tx_error;
	} tx_status_t;

	// Status register layout
	localparam int STATUS_BITS     = 16;
	localparam int STAT_DATA_READY = 0;
	localparam int STAT_IN         = 1;
	localparam int STAT_OUT        = 2;
	localparam int STAT_ACK        = 3;
	localparam int STAT_RX_ACTIVE  = 8;
	localparam int STAT_TX_ACTIVE  = 9;

	// Error register layout
	localparam int ERROR_BITS = 16;
	localparam int ERR_RX     = 0;
	localparam int ERR_TX     = 8;

endpackage

/* usb_status_regs.sv */
// Endpoint status and control registers
// Builds the status, error and occupancy read words and holds the
// self-clearing TX packet control and buffer flush registers
`timescale 1ns/1ns

module usb_status_regs (
	input  logic                   tb_clk,
	input  logic                   reset,
	input  ahb_pkg::access_t       access,
	input  ahb_pkg::hdata_t        hwdata,
	input  usb_ep_pkg::rx_status_t rx_status,
	input  usb_ep_pkg::tx_status_t tx_status,
	input  usb_ep_pkg::occupancy_t buffer_occupancy,
	output ahb_pkg::hdata_t        reg_rdata,
	output usb_ep_pkg::packet_t    tx_packet,
	output logic                   clear
);
	import ahb_pkg::*;
	import usb_ep_pkg::*;

	logic [STATUS_BITS-1:0] status_word;
	logic [ERROR_BITS-1:0]  error_word;
	logic                   reg_write;
	logic                   wr_tx;
	logic                   wr_flush;
	logic                   tx_active_q;

	// ************************************************************
	// Register writes, data phase
	// ************************************************************
	assign reg_write = access.valid && access.write && !access.is_buffer;
	assign wr_tx     = reg_write && (access.addr == ADDR_TX_CTRL);
	// Halfword at 0xC also covers the flush byte
	assign wr_flush  = reg_write && ((access.addr == ADDR_FLUSH) ||
		(access.addr == ADDR_TX_CTRL && access.size == SIZE_HALF));

	// TX packet control, cleared once the transmitter finishes
	always_ff @(posedge tb_clk)
	begin
		if (reset)
		begin
			tx_packet   <= PKT_NONE;
			tx_active_q <= 1'b0;
		end
		else
		begin
			tx_active_q <= tx_status.tx_transfer_active;
			if (wr_tx)
				tx_packet <= packet_t'(hwdata[2:0]);
			else if (tx_active_q && !tx_status.tx_transfer_active)
				tx_packet <= PKT_NONE;
		end
	end

	// Flush control, lane 1, held until the buffer drains
	always_ff @(posedge tb_clk)
	begin
		if (reset)
			clear <= 1'b0;
		else if (wr_flush)
			clear <= hwdata[8];
		else if (buffer_occupancy == '0)
			clear <= 1'b0;
	end

	// ************************************************************
	// Read words
	// ************************************************************
	always_comb
	begin
		status_word                  = '0;
		status_word[STAT_DATA_READY] = rx_status.rx_data_ready;
		status_word[STAT_IN]         = (rx_status.rx_packet == PKT_IN);
		status_word[STAT_OUT]        = (rx_status.rx_packet == PKT_OUT);
		status_word[STAT_ACK]        = (rx_status.rx_packet == PKT_ACK);
		status_word[STAT_RX_ACTIVE]  = rx_status.rx_transfer_active;
		status_word[STAT_TX_ACTIVE]  = tx_status.tx_transfer_active;
		error_word                   = '0;
		error_word[ERR_RX]           = rx_status.rx_error;
		error_word[ERR_TX]           = tx_status.tx_error;
	end

	// Byte lanes follow the low address bits
	always_comb
	begin
		case (access.addr[3:2])
			ADDR_STATUS[3:2]: reg_rdata = {error_word, status_word};
			ADDR_OCCUPANCY[3:2]: reg_rdata = hdata_t'(buffer_occupancy);
			ADDR_TX_CTRL[3:2]: reg_rdata = {16'h0000, 7'h00, clear, 5'h00, tx_packet};
			default: reg_rdata = '0;
		endcase
	end

endmodule
